// File: include/fetch_defs.svh
// Fetch front end constants
// Reset PC and the bus wait limit for instruction reads

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// First instruction address after reset
`define FETCH_RESET_PC 32'h0000_0100

// Busy cycles after which an instruction read is declared faulted
`define FETCH_BUS_WAIT_MAX 8

`endif

// File: hdl/fetch_pkg.sv
// Fetch front end types
// Word and opcode types, branch and JAL instruction overlays,
// fetch/execute pipeline register layout

`default_nettype none

package fetch_pkg;

    typedef logic [31:0] word_t;

    // Major opcodes the front end needs to tell apart
    typedef enum logic [6:0] {
        OTHER  = 7'b0000000,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_t;

    // Conditional branch format
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_05;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm04_01;
        logic       imm11;
        opcode_t    opcode;
    } sbtype_t;

    // JAL format
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_01;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } ujtype_t;

    // Fetch to execute pipeline register
    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
        word_t pc4;
        logic  prediction;
        word_t predicted_address;
        logic  fault_insn;
        word_t fault_addr;
    } fetch_ex_t;

endpackage

`default_nettype wire

// File: hdl/fetch_bus_if.sv
// Instruction word bus
// Read enable, address, read data, busy and error flag

`timescale 1ns/100ps
`default_nettype none

interface fetch_bus_if;

    fetch_pkg::word_t addr;
    fetch_pkg::word_t rdata;
    logic             ren;
    logic             busy;
    logic             error;

    // Fetch side issues reads
    modport requester (
        output addr, ren,
        input  rdata, busy, error
    );

    // Memory side, used to reach the top-level pins
    modport memory (
        input  addr, ren,
        output rdata, busy, error
    );

endinterface

`default_nettype wire

// File: hdl/bus_wait_timer.sv
// Busy cycle counter for the outstanding instruction read
// Flags expiry on the last allowed busy cycle

`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module bus_wait_timer (
    input  logic CLK,
    input  logic nRST,
    input  logic count_en,
    input  logic clear,
    output logic expired
);

    localparam int WAIT_MAX = `FETCH_BUS_WAIT_MAX;
    localparam int CW       = $clog2(WAIT_MAX) + 1;

    logic [CW-1:0] count;

    // Busy cycle number WAIT_MAX sees a count of WAIT_MAX-1
    assign expired = count_en && (count == CW'(WAIT_MAX - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (count_en && (count != CW'(WAIT_MAX))) begin
            // Saturates at the limit
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/static_predictor.sv
// Static branch predictor
// Backward branches and JAL predicted taken, target is pc plus immediate

`timescale 1ns/100ps
`default_nettype none

module static_predictor (
    input  fetch_pkg::word_t pc,
    input  fetch_pkg::word_t instr,
    input  logic             valid,
    output logic             predict_taken,
    output fetch_pkg::word_t target_addr
);

    fetch_pkg::sbtype_t instr_sb;
    fetch_pkg::ujtype_t instr_uj;
    fetch_pkg::word_t   imm_sb;
    fetch_pkg::word_t   imm_uj;
    logic               is_branch;
    logic               is_jal;

    assign instr_sb = fetch_pkg::sbtype_t'(instr);
    assign instr_uj = fetch_pkg::ujtype_t'(instr);

    // Sign-extended immediates, bit 0 is always zero
    assign imm_sb = {{19{instr_sb.imm12}}, instr_sb.imm12, instr_sb.imm11,
                     instr_sb.imm10_05, instr_sb.imm04_01, 1'b0};
    assign imm_uj = {{11{instr_uj.imm20}}, instr_uj.imm20, instr_uj.imm19_12,
                     instr_uj.imm11, instr_uj.imm10_01, 1'b0};

    assign is_branch = (instr_sb.opcode == fetch_pkg::BRANCH);
    assign is_jal    = (instr_uj.opcode == fetch_pkg::JAL);

    assign target_addr = pc + (is_jal ? imm_uj : imm_sb);

    // JALR target depends on a register, so it falls through to pc+4
    // Sign bit of the branch offset marks a backward branch
    assign predict_taken = valid && (is_jal || (is_branch && instr_sb.imm12));

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
// Instruction fetch FSM
// Issues bus reads at the PC, holds a returned word across a stall,
// reports ready and fault to the fetch stage

`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  ireq,
    input  logic                  stall,
    input  logic                  pc_redirect,
    input  fetch_pkg::word_t      pc,
    output logic                  insn_ready,
    output logic                  insn_fault,
    output fetch_pkg::word_t      insn_out,
    input  logic                  expired,
    output logic                  count_en,
    output logic                  clear,
    fetch_bus_if.requester        bus
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        HOLD
    } state_t;

    state_t           state;
    state_t           next_state;
    fetch_pkg::word_t held_word;
    logic             held_fault;
    logic             bus_done;
    logic             got_word;
    logic             got_fault;

    // A read completes on the first non-busy cycle, or times out
    assign bus_done  = (state == REQUEST) && !bus.busy;
    assign got_word  = bus_done || expired;
    assign got_fault = (bus_done && bus.error) || expired;

    assign bus.ren  = (state == REQUEST);
    assign bus.addr = pc;

    // Timer sees only busy cycles of the outstanding read
    assign count_en = (state == REQUEST) && bus.busy;
    assign clear    = (state != REQUEST) || got_word || pc_redirect;

    always_comb begin
        if (state == HOLD) begin
            insn_ready = !pc_redirect;
            insn_fault = held_fault;
            insn_out   = held_word;
        end else begin
            // A redirect discards whatever returns in the same cycle
            insn_ready = got_word && !pc_redirect;
            insn_fault = got_fault;
            insn_out   = expired ? '0 : bus.rdata;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (ireq) begin
                    next_state = REQUEST;
                end
            end
            REQUEST: begin
                if (pc_redirect) begin
                    next_state = REQUEST;
                end else if (got_word && stall) begin
                    next_state = HOLD;
                end else if (!ireq) begin
                    next_state = IDLE;
                end
            end
            HOLD: begin
                // Held word is consumed in the first cycle without stall
                if (pc_redirect || !stall) begin
                    next_state = REQUEST;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Word and fault captured when the read finishes under stall
    always_ff @(posedge CLK) begin
        if ((state == REQUEST) && got_word && stall) begin
            held_word  <= expired ? '0 : bus.rdata;
            held_fault <= got_fault;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
// Fetch stage
// PC register, next-PC selection, fault squashing and the
// fetch/execute pipeline register

`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_stage (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  npc_sel,
    input  fetch_pkg::word_t      brj_addr,
    output fetch_pkg::fetch_ex_t  ex_reg,
    fetch_bus_if.requester        bus
);

    fetch_pkg::word_t pc;
    fetch_pkg::word_t pc4;
    fetch_pkg::word_t npc;
    fetch_pkg::word_t insn_out;
    fetch_pkg::word_t target_addr;
    logic             ireq;
    logic             pc_redirect;
    logic             insn_ready;
    logic             insn_fault;
    logic             pred_valid;
    logic             predict_taken;
    logic             count_en;
    logic             clear;
    logic             expired;

    // No privilege or TLB suppression in this core
    assign ireq        = 1'b1;
    assign pc_redirect = npc_sel;
    assign pc4         = pc + 32'd4;

    // Faulted words are never predicted
    assign pred_valid = insn_ready && !insn_fault;

    assign npc = npc_sel       ? brj_addr
               : predict_taken ? target_addr
               : pc4;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= `FETCH_RESET_PC;
        end else if (npc_sel || (insn_ready && !stall)) begin
            pc <= npc;
        end
    end

    fetch_unit u_fetch_unit (
        .CLK         (CLK),
        .nRST        (nRST),
        .ireq        (ireq),
        .stall       (stall),
        .pc_redirect (pc_redirect),
        .pc          (pc),
        .insn_ready  (insn_ready),
        .insn_fault  (insn_fault),
        .insn_out    (insn_out),
        .expired     (expired),
        .count_en    (count_en),
        .clear       (clear),
        .bus         (bus)
    );

    bus_wait_timer u_bus_wait_timer (
        .CLK      (CLK),
        .nRST     (nRST),
        .count_en (count_en),
        .clear    (clear),
        .expired  (expired)
    );

    static_predictor u_static_predictor (
        .pc            (pc),
        .instr         (insn_out),
        .valid         (pred_valid),
        .predict_taken (predict_taken),
        .target_addr   (target_addr)
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ex_reg <= '0;
        end else if (!stall) begin
            if (flush || !insn_ready) begin
                // Flushed entry or bubble
                ex_reg <= '0;
            end else begin
                ex_reg.valid             <= 1'b1;
                // Squashed to zero on a fault, still valid for the trap logic
                ex_reg.instr             <= insn_fault ? '0 : insn_out;
                ex_reg.pc                <= pc;
                ex_reg.pc4               <= pc4;
                ex_reg.prediction        <= predict_taken;
                ex_reg.predicted_address <= target_addr;
                ex_reg.fault_insn        <= insn_fault;
                ex_reg.fault_addr        <= pc;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_frontend.sv
// Instruction fetch front end top level
// Instruction bus and fetch/execute register brought out as plain ports

`timescale 1ns/100ps
`default_nettype none

module fetch_frontend (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        stall,
    input  logic        flush,
    input  logic        npc_sel,
    input  logic [31:0] brj_addr,
    output logic [31:0] iaddr,
    output logic        iren,
    input  logic [31:0] irdata,
    input  logic        ibusy,
    input  logic        ierror,
    output logic        ex_valid,
    output logic        ex_prediction,
    output logic        ex_fault,
    output logic [31:0] ex_instr,
    output logic [31:0] ex_pc,
    output logic [31:0] ex_pc4,
    output logic [31:0] ex_pred_target,
    output logic [31:0] ex_fault_addr
);

    fetch_pkg::fetch_ex_t ex_reg;

    fetch_bus_if ibus ();

    // Memory side of the bus to the pins
    assign iaddr      = ibus.addr;
    assign iren       = ibus.ren;
    assign ibus.rdata = irdata;
    assign ibus.busy  = ibusy;
    assign ibus.error = ierror;

    fetch_stage u_fetch_stage (
        .CLK      (CLK),
        .nRST     (nRST),
        .stall    (stall),
        .flush    (flush),
        .npc_sel  (npc_sel),
        .brj_addr (brj_addr),
        .ex_reg   (ex_reg),
        .bus      (ibus)
    );

    assign ex_valid       = ex_reg.valid;
    assign ex_prediction  = ex_reg.prediction;
    assign ex_fault       = ex_reg.fault_insn;
    assign ex_instr       = ex_reg.instr;
    assign ex_pc          = ex_reg.pc;
    assign ex_pc4         = ex_reg.pc4;
    assign ex_pred_target = ex_reg.predicted_address;
    assign ex_fault_addr  = ex_reg.fault_addr;

endmodule

`default_nettype wire

// File: verif/fetch_frontend_tb.sv
// Testbench for the instruction fetch front end
// Clock and reset, word bus memory model fed from a vector file,
// expected-entry queue and output checks

`timescale 1ns/100ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_frontend_tb;

    localparam int WAIT_MAX    = `FETCH_BUS_WAIT_MAX;
    localparam int MAX_TESTS   = 32;
    localparam int REQ_TIMEOUT = 20;

    logic        CLK, nRST, stall, flush, npc_sel, ibusy, ierror;
    logic [31:0] brj_addr, irdata, iaddr;
    logic        iren, ex_valid, ex_prediction, ex_fault;
    logic [31:0] ex_instr, ex_pc, ex_pc4, ex_pred_target, ex_fault_addr;

    logic [31:0] vec [0:7*MAX_TESTS-1];
    fetch_pkg::fetch_ex_t exp_q[$];
    logic [31:0] exp_pc;
    logic [31:0] lfsr;
    int          errors, bad_tests, num_tests, t;

    fetch_frontend dut0 (
        .CLK(CLK), .nRST(nRST), .stall(stall), .flush(flush), .npc_sel(npc_sel),
        .brj_addr(brj_addr), .iaddr(iaddr), .iren(iren), .irdata(irdata),
        .ibusy(ibusy), .ierror(ierror), .ex_valid(ex_valid),
        .ex_prediction(ex_prediction), .ex_fault(ex_fault), .ex_instr(ex_instr),
        .ex_pc(ex_pc), .ex_pc4(ex_pc4), .ex_pred_target(ex_pred_target),
        .ex_fault_addr(ex_fault_addr)
    );

    always #20 CLK = ~CLK;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Returns {taken, target} from the RV32I branch and JAL encodings
    function automatic logic [32:0] static_prediction(input logic [31:0] w,
                                                      input logic [31:0] pc);
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic        is_jal;
        imm_b  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        is_jal = (w[6:0] == 7'h6f);
        return {is_jal || ((w[6:0] == 7'h63) && w[31]), pc + (is_jal ? imm_j : imm_b)};
    endfunction

    // Inputs change a little after the rising edge
    task automatic step();
        @(posedge CLK);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_request();
        int n;
        n = 0;
        while (!iren && n < REQ_TIMEOUT) begin
            step();
            n++;
        end
        if (!iren) begin
            $display("Timed out waiting for an instruction read request at %0t", $time);
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic check_entry();
        fetch_pkg::fetch_ex_t e;
        e = exp_q.pop_front();
        check_value("ex_valid", 32'(ex_valid), 32'(e.valid));
        if (e.valid) begin
            check_value("ex_instr", ex_instr, e.instr);
            check_value("ex_pc", ex_pc, e.pc);
            check_value("ex_pc4", ex_pc4, e.pc4);
            check_value("ex_prediction", 32'(ex_prediction), 32'(e.prediction));
            check_value("ex_fault", 32'(ex_fault), 32'(e.fault_insn));
            if (e.prediction)
                check_value("ex_pred_target", ex_pred_target, e.predicted_address);
            if (e.fault_insn)
                check_value("ex_fault_addr", ex_fault_addr, e.fault_addr);
        end
    endtask

    task automatic run_test(input int n);
        logic [31:0] word, busy, err, nstall, fl, redir, target, snap_pc;
        logic [32:0] pred;
        logic        fault, snap_valid;
        fetch_pkg::fetch_ex_t e;
        int          i, c, errs_before;
        word   = vec[7*n];
        busy   = vec[7*n+1];
        err    = vec[7*n+2];
        nstall = vec[7*n+3];
        fl     = vec[7*n+4];
        redir  = vec[7*n+5];
        target = vec[7*n+6];
        errs_before = errors;
        // Extra random stall on the last plain tests
        if (n >= num_tests - 4 && nstall == 0 && fl == 0 && redir == 0) begin
            lfsr = lfsr_next(lfsr);
            nstall[0] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            nstall[1] = lfsr[0];
        end
        wait_request();
        check_value("iaddr", iaddr, exp_pc);
        // Timeout completes on the busy cycle numbered WAIT_MAX
        c = (busy >= WAIT_MAX) ? WAIT_MAX - 1 : busy;
        for (i = 0; i < c; i++) begin
            ibusy = 1'b1;
            step();
        end
        ibusy      = (busy >= WAIT_MAX);
        ierror     = err[0];
        irdata     = word;
        stall      = (nstall != 0);
        flush      = fl[0];
        npc_sel    = redir[0];
        brj_addr   = target;
        snap_valid = ex_valid;
        snap_pc    = ex_pc;
        fault = err[0] || (busy >= WAIT_MAX);
        pred  = static_prediction(word, exp_pc);
        e = '0;
        if (!fl[0] && !redir[0]) begin
            e.valid             = 1'b1;
            e.instr             = fault ? 32'd0 : word;
            e.pc                = exp_pc;
            e.pc4               = exp_pc + 32'd4;
            e.prediction        = !fault && pred[32];
            e.predicted_address = pred[31:0];
            e.fault_insn        = fault;
            e.fault_addr        = exp_pc;
        end
        exp_q.push_back(e);
        if (redir[0])
            exp_pc = target;
        else if (!fault && pred[32])
            exp_pc = pred[31:0];
        else
            exp_pc = exp_pc + 32'd4;
        step();
        ibusy   = 1'b0;
        ierror  = 1'b0;
        flush   = 1'b0;
        npc_sel = 1'b0;
        // Held word, no request and a frozen register while stalled
        for (i = 1; i <= nstall; i++) begin
            check_value("iren", 32'(iren), 32'd0);
            check_value("ex_valid", 32'(ex_valid), 32'(snap_valid));
            check_value("ex_pc", ex_pc, snap_pc);
            if (i == nstall)
                stall = 1'b0;
            step();
        end
        check_entry();
        if (errors != errs_before) begin
            bad_tests++;
            $display("test %0d word %h: %0d mismatches", n, word, errors - errs_before);
        end else begin
            $display("test %0d word %h: ok", n, word);
        end
    endtask

    initial begin
        CLK       = 1'b0;
        nRST      = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        npc_sel   = 1'b0;
        ibusy     = 1'b0;
        ierror    = 1'b0;
        brj_addr  = '0;
        irdata    = '0;
        errors    = 0;
        bad_tests = 0;
        num_tests = 0;
        lfsr      = 32'hc7cff904;
        exp_pc    = `FETCH_RESET_PC;
        $readmemh("verif/fetch_tests.txt", vec);
        while (num_tests < MAX_TESTS && vec[7*num_tests+1] != 32'hffff_ffff)
            num_tests++;
        repeat (2) @(posedge CLK);
        #2;
        nRST = 1'b1;
        check_value("iren", 32'(iren), 32'd0);
        check_value("ex_valid", 32'(ex_valid), 32'd0);
        check_value("ex_instr", ex_instr, 32'd0);
        check_value("ex_pc", ex_pc, 32'd0);
        check_value("ex_pc4", ex_pc4, 32'd0);
        check_value("ex_prediction", 32'(ex_prediction), 32'd0);
        check_value("ex_fault", 32'(ex_fault), 32'd0);
        check_value("ex_pred_target", ex_pred_target, 32'd0);
        check_value("ex_fault_addr", ex_fault_addr, 32'd0);
        for (t = 0; t < num_tests; t++)
            run_test(t);
        $display("Tests run: %0d, tests with mismatches: %0d, failed checks: %0d",
                 num_tests, bad_tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fetch_frontend.f
+incdir+include
hdl/fetch_pkg.sv
hdl/fetch_bus_if.sv
hdl/bus_wait_timer.sv
hdl/static_predictor.sv
hdl/fetch_unit.sv
hdl/fetch_stage.sv
hdl/fetch_frontend.sv
verif/fetch_frontend_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f fetch_frontend.f --top-module fetch_frontend_tb \
    --Mdir obj_dir -o fetch_sim \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || { echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "No result in sim.log"; exit 1; }
echo "PASS"

// File: verif/fetch_tests.txt
// instr    busy     error    stall    flush    redirect target   (all hex)
// A busy value of ffffffff ends the list
00000013 0 0 0 0 0 0
00100093 2 0 0 0 0 0
fe000ce3 0 0 0 0 0 0
00209863 1 0 0 0 0 0
020000ef 0 0 2 0 0 0
000080e7 3 0 0 0 0 0
00000013 0 1 0 0 0 0
fe000ce3 9 0 0 0 0 0
00100093 7 0 0 0 0 0
020000ef 0 0 0 0 1 00000200
00000013 1 0 0 1 0 0
fe000ce3 0 0 3 0 0 0
00000013 2 0 0 0 0 0
00100093 0 0 0 0 0 0
00000013 1 0 0 0 0 0
020000ef 2 0 0 0 0 0
00000013 0 0 0 0 0 0
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
